// ==== design/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Core-wide sizes, fixed by the instruction set

// Register and data word width
`define DATA_WIDTH 32

// Width of a register index (rs, rt, rd fields)
`define REG_BITS 5

// Architectural registers
`define REG_COUNT 32

// Return address register written by JAL
`define RA_REG 31

`endif

// ==== design/isaPkg.sv ====
`include "core_config.svh"

// Instruction encoding of the MIPS-style subset
package isaPkg;

	////////////////////
	// Field types
	typedef logic [`DATA_WIDTH-1:0] wordT;
	typedef logic [`REG_BITS-1:0] regIdxT;
	// Shift amount is as wide as a register index
	typedef logic [`REG_BITS-1:0] shamtT;

	////////////////////
	// Primary opcodes, bits 31:26
	typedef enum logic [5:0]
	{
		OP_RTYPE = 6'h00,
		OP_JAL   = 6'h03,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f
	} opcodeT;

	////////////////////
	// R-type function codes, bits 5:0
	typedef enum logic [5:0]
	{
		// All-zero word is SLL r0, r0, 0 (the usual nop)
		FN_SLL = 6'h00,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_XOR = 6'h26,
		FN_NOR = 6'h27,
		FN_SLT = 6'h2a
	} functT;

endpackage

// ==== design/ctrlPkg.sv ====
// Decoded controls passed from the decoder to the ALU
package ctrlPkg;

	////////////////////
	// ALU operations
	typedef enum logic [3:0]
	{
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		// Signed compare
		ALU_SLT  = 4'd6,
		// Shift of rt by shamt
		ALU_SLL  = 4'd7,
		// Immediate into upper half
		ALU_LUI  = 4'd8,
		// pc + 4 for jump-and-link
		ALU_LINK = 4'd9
	} aluOpT;

	////////////////////
	// Second operand source
	typedef enum logic
	{
		SRC_REG = 1'b0,
		SRC_IMM = 1'b1
	} srcBT;

endpackage

// ==== design/execIfs.sv ====
`timescale 1ns/1ns

////////////////////
// Decoder to ALU controls
interface decodeIf
	import isaPkg::*, ctrlPkg::*;
	();

	// Legal instruction present this cycle
	logic valid;
	aluOpT aluOp;
	srcBT srcB;
	// Already extended to a full word
	wordT imm;
	shamtT shamt;
	regIdxT dest;

	// Decoder side
	modport source (output valid, aluOp, srcB, imm, shamt, dest);

	// ALU side
	modport sink (input valid, aluOp, srcB, imm, shamt, dest);

endinterface

////////////////////
// ALU to register file write port
interface writebackIf
	import isaPkg::*;
	();

	// Combinational within the instruction's cycle
	logic writeEn;
	regIdxT dest;
	wordT data;

	// ALU drives
	modport source (output writeEn, dest, data);

	// Register file takes it at the rising edge
	modport sink (input writeEn, dest, data);

endinterface

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ns

`include "core_config.svh"

module instrDecoder
	import isaPkg::*, ctrlPkg::*;
	(
		input wordT instruction,
		input logic instrValid,
		decodeIf.source dec,
		output logic illegal
	);

	////////////////////
	// Instruction fields
	opcodeT opcode;
	functT funct;
	regIdxT rtField;
	regIdxT rdField;
	logic [15:0] immField;
	wordT immSext;
	wordT immZext;
	// Encoding recognized
	logic known;

	assign opcode = opcodeT'(instruction[31:26]);
	assign funct = functT'(instruction[5:0]);
	assign rtField = instruction[20:16];
	assign rdField = instruction[15:11];
	assign immField = instruction[15:0];

	// Both extensions of the 16-bit immediate
	assign immSext = {{(`DATA_WIDTH-16){immField[15]}}, immField};
	assign immZext = {{(`DATA_WIDTH-16){1'b0}}, immField};

	// Shift amount passes straight through
	assign dec.shamt = instruction[10:6];

	////////////////////
	// Operation select
	always_comb
	begin
		// Defaults suit R-type
		dec.aluOp = ALU_ADD;
		dec.srcB = SRC_REG;
		dec.imm = immSext;
		dec.dest = rdField;
		known = 1'b1;
		case (opcode)
			OP_RTYPE:
			begin
				// Function field picks the operation
				case (funct)
					FN_SLL: dec.aluOp = ALU_SLL;
					FN_ADD: dec.aluOp = ALU_ADD;
					FN_SUB: dec.aluOp = ALU_SUB;
					FN_AND: dec.aluOp = ALU_AND;
					FN_OR: dec.aluOp = ALU_OR;
					FN_XOR: dec.aluOp = ALU_XOR;
					FN_NOR: dec.aluOp = ALU_NOR;
					FN_SLT: dec.aluOp = ALU_SLT;
					default: known = 1'b0;
				endcase
			end
			OP_JAL:
			begin
				// Link value lands in the return address register
				dec.aluOp = ALU_LINK;
				dec.dest = regIdxT'(`RA_REG);
			end
			OP_ADDI, OP_SLTI, OP_LUI:
			begin
				// Sign-extended immediate forms
				dec.aluOp = (opcode == OP_ADDI) ? ALU_ADD : (opcode == OP_SLTI) ? ALU_SLT : ALU_LUI;
				dec.srcB = SRC_IMM;
				dec.dest = rtField;
			end
			OP_ANDI, OP_ORI:
			begin
				// Logical immediates are zero-extended
				dec.aluOp = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
				dec.srcB = SRC_IMM;
				dec.imm = immZext;
				dec.dest = rtField;
			end
			default: known = 1'b0;
		endcase
	end

	// Unknown encodings never reach the ALU
	assign dec.valid = instrValid & known;
	assign illegal = instrValid & ~known;

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ns

`include "core_config.svh"

module regFile
	import isaPkg::*;
	(
		input logic clk,
		input logic rst,
		// Source register indices
		input regIdxT rs,
		input regIdxT rt,
		output wordT rsData,
		output wordT rtData,
		// Return address, always visible
		output wordT raData,
		writebackIf.sink wb
	);

	////////////////////
	// Storage
	wordT regs [`REG_COUNT];

	// Write on the rising edge, clear everything on reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wb.writeEn)
		begin
			// Register 0 may be written but never reads back
			regs[wb.dest] <= wb.data;
		end
	end

	////////////////////
	// Read ports
	// Register 0 is hardwired to zero
	assign rsData = (rs != '0) ? regs[rs] : '0;
	assign rtData = (rt != '0) ? regs[rt] : '0;

	// Continuous view of the link register
	assign raData = regs[`RA_REG];

endmodule

// ==== design/aluUnit.sv ====
`timescale 1ns/1ns

`include "core_config.svh"

module aluUnit
	import isaPkg::*, ctrlPkg::*;
	(
		input logic clk,
		input logic rst,
		decodeIf.sink dec,
		// Operands from the register file
		input wordT rsData,
		input wordT rtData,
		// Address of the current instruction
		input wordT pc,
		input logic illegalIn,
		writebackIf.source wb,
		output wordT result,
		output logic resultValid,
		output logic illegal
	);

	wordT opB;
	wordT aluOut;
	logic lessThan;

	// Second operand mux
	assign opB = (dec.srcB == SRC_IMM) ? dec.imm : rtData;

	// Signed compare for SLT and SLTI
	assign lessThan = $signed(rsData) < $signed(opB);

	////////////////////
	// Datapath
	always_comb
	begin
		case (dec.aluOp)
			// Wraparound, no overflow trap
			ALU_ADD: aluOut = rsData + opB;
			ALU_SUB: aluOut = rsData - opB;
			ALU_AND: aluOut = rsData & opB;
			ALU_OR: aluOut = rsData | opB;
			ALU_XOR: aluOut = rsData ^ opB;
			ALU_NOR: aluOut = ~(rsData | opB);
			ALU_SLT: aluOut = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
			// Shift source is rt, not rs
			ALU_SLL: aluOut = rtData << dec.shamt;
			// Low half of the immediate moves up
			ALU_LUI:
			begin
				aluOut = {dec.imm[`DATA_WIDTH/2-1:0], {(`DATA_WIDTH/2){1'b0}}};
			end
			// Return address of a jump-and-link
			ALU_LINK: aluOut = pc + wordT'(4);
			default: aluOut = '0;
		endcase
	end

	////////////////////
	// Write-back, same cycle
	assign wb.writeEn = dec.valid;
	assign wb.dest = dec.dest;
	assign wb.data = aluOut;

	// Reported result, one cycle after the instruction
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result <= '0;
			resultValid <= 1'b0;
			illegal <= 1'b0;
		end
		else
		begin
			// Holds the last result between instructions
			if (dec.valid)
			begin
				result <= aluOut;
			end
			resultValid <= dec.valid;
			// Single-cycle pulse
			illegal <= illegalIn;
		end
	end

endmodule

// ==== design/execCore.sv ====
`timescale 1ns/1ns

module execCore
	import isaPkg::*;
	(
		input logic clk,
		input logic rst,
		// Instruction word and its strobe
		input wordT instruction,
		input logic instrValid,
		input wordT pc,
		// Registered outputs
		output wordT result,
		output logic resultValid,
		output logic illegal,
		// Return address register
		output wordT raData
	);

	regIdxT rsIdx;
	regIdxT rtIdx;
	wordT rsData;
	wordT rtData;
	// Combinational illegal flag from the decoder
	logic decIllegal;

	decodeIf decBus ();
	writebackIf wbBus ();

	// Register indices come straight from the raw fields
	assign rsIdx = instruction[25:21];
	assign rtIdx = instruction[20:16];

	////////////////////
	// Decode and register read in parallel
	instrDecoder decoder (
		.instruction (instruction),
		.instrValid (instrValid),
		.dec (decBus.source),
		.illegal (decIllegal)
	);

	regFile regs (
		.clk (clk),
		.rst (rst),
		.rs (rsIdx),
		.rt (rtIdx),
		.rsData (rsData),
		.rtData (rtData),
		.raData (raData),
		.wb (wbBus.sink)
	);

	////////////////////
	// Execute and write back
	aluUnit alu (
		.clk (clk),
		.rst (rst),
		.dec (decBus.sink),
		.rsData (rsData),
		.rtData (rtData),
		.pc (pc),
		.illegalIn (decIllegal),
		.wb (wbBus.source),
		.result (result),
		.resultValid (resultValid),
		.illegal (illegal)
	);

endmodule

// ==== tests/execCore_assert.sv ====
`timescale 1ns/1ns

module execCore_assert
	(
		input logic clk,
		input logic rst,
		input logic instrValid,
		input logic resultValid,
		input logic illegal
	);

	// A result and an illegal pulse exclude each other
	exclusiveFlags: assert property (@(posedge clk) disable iff (rst)
		!(resultValid && illegal))
		else $error("resultValid and illegal high together");

	// Both flags come from an instruction one cycle earlier
	resultFollowsValid: assert property (@(posedge clk) disable iff (rst)
		resultValid |-> $past(instrValid))
		else $error("resultValid without a preceding instrValid");

	illegalFollowsValid: assert property (@(posedge clk) disable iff (rst)
		illegal |-> $past(instrValid))
		else $error("illegal without a preceding instrValid");

	// Every strobe produces exactly one of them
	validAnswered: assert property (@(posedge clk) disable iff (rst)
		instrValid |=> (resultValid || illegal))
		else $error("instrValid produced neither resultValid nor illegal");

	// Quiet while in reset
	quietInReset: assert property (@(posedge clk)
		$past(rst) |-> (!resultValid && !illegal))
		else $error("Output flag high during reset");

endmodule

bind execCore execCore_assert checks (
	.clk (clk),
	.rst (rst),
	.instrValid (instrValid),
	.resultValid (resultValid),
	.illegal (illegal)
);

// ==== tests/execCoreTb.sv ====
`timescale 1ns/1ns

`include "core_config.svh"

module execCoreTb
	import isaPkg::*;
	();

	// Section sizes
	localparam int N_START = `REG_COUNT;
	localparam int N_IMM = 300;
	localparam int N_RTYPE = 300;
	localparam int N_CHAIN = 100;
	localparam int N_JAL = 40;
	localparam int N_ILLEGAL = 60;
	// Worst case with gaps and follow-up reads
	localparam int N_CYCLES = 6 + N_START + N_IMM + N_RTYPE + 2 * N_CHAIN
		+ 2 * N_JAL + 2 * N_ILLEGAL;

	logic clk;
	logic rst;
	wordT instruction;
	logic instrValid;
	wordT pc;
	wordT result;
	logic resultValid;
	logic illegal;
	wordT raData;

	////////////////////
	// Model state
	wordT model [`REG_COUNT];
	// Result output holds between instructions
	wordT lastResult;
	wordT pcNext;
	logic [15:0] lfsrState;

	// Pick tables indexed by three random bits
	functT fnList [8] = '{FN_SLL, FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
	opcodeT immOps [8] = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI, OP_ADDI, OP_ORI, OP_LUI};

	execCore uut (
		.clk (clk),
		.rst (rst),
		.instruction (instruction),
		.instrValid (instrValid),
		.pc (pc),
		.result (result),
		.resultValid (resultValid),
		.illegal (illegal),
		.raData (raData)
	);

	always #10 clk = ~clk;

	////////////////////
	// Random source
	function automatic logic galoisStep();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		// Taps 16, 14, 13, 11
		if (outBit)
		begin
			lfsrState = lfsrState ^ 16'hB400;
		end
		return outBit;
	endfunction

	// One step per bit taken
	function automatic wordT randBits(input int n);
		wordT bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[`DATA_WIDTH-2:0], galoisStep()};
		end
		return bits;
	endfunction

	function automatic regIdxT randReg();
		wordT w;
		w = randBits(`REG_BITS);
		return w[`REG_BITS-1:0];
	endfunction

	////////////////////
	// Instruction encoders
	function automatic wordT encodeR(functT fn, regIdxT rs, regIdxT rt, regIdxT rd,
		logic [4:0] shamt);
		return {OP_RTYPE, rs, rt, rd, shamt, fn};
	endfunction

	function automatic wordT encodeI(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic wordT encodeJ(logic [25:0] target);
		return {OP_JAL, target};
	endfunction

	////////////////////
	// Reference model of decode and execute
	function automatic logic modelExec(input wordT instr, input wordT pcVal,
		output regIdxT dest, output wordT value);
		wordT a;
		wordT b;
		wordT sImm;
		wordT zImm;
		logic legal;
		a = model[instr[25:21]];
		b = model[instr[20:16]];
		sImm = {{16{instr[15]}}, instr[15:0]};
		zImm = {16'h0000, instr[15:0]};
		legal = 1'b1;
		// Immediate forms write rt
		dest = instr[20:16];
		value = '0;
		case (opcodeT'(instr[31:26]))
			OP_RTYPE:
			begin
				dest = instr[15:11];
				case (functT'(instr[5:0]))
					FN_SLL: value = b << instr[10:6];
					FN_ADD: value = a + b;
					FN_SUB: value = a - b;
					FN_AND: value = a & b;
					FN_OR: value = a | b;
					FN_XOR: value = a ^ b;
					FN_NOR: value = ~(a | b);
					FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: legal = 1'b0;
				endcase
			end
			OP_JAL:
			begin
				dest = regIdxT'(`RA_REG);
				value = pcVal + 32'd4;
			end
			OP_ADDI: value = a + sImm;
			OP_SLTI: value = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
			// Logical immediates zero-extended
			OP_ANDI: value = a & zImm;
			OP_ORI: value = a | zImm;
			OP_LUI: value = {instr[15:0], 16'h0000};
			default: legal = 1'b0;
		endcase
		return legal;
	endfunction

	function automatic logic isLegal(input wordT instr);
		regIdxT d;
		wordT v;
		return modelExec(instr, '0, d, v);
	endfunction

	////////////////////
	// Compare tasks
	task automatic checkWord(input string name, input wordT got, input wordT expected);
		if (got !== expected)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	////////////////////
	// Drive one instruction and check it one cycle later
	task automatic issue(input wordT instr, input wordT pcVal);
		regIdxT dest;
		wordT value;
		logic legal;
		legal = modelExec(instr, pcVal, dest, value);
		instruction = instr;
		pc = pcVal;
		instrValid = 1'b1;
		pcNext = pcVal + 32'd4;
		@(posedge clk);
		#1;
		// Register 0 never changes in the model
		if (legal)
		begin
			lastResult = value;
			if (dest != '0)
			begin
				model[dest] = value;
			end
		end
		checkFlag("resultValid", resultValid, legal);
		checkFlag("illegal", illegal, ~legal);
		checkWord("result", result, lastResult);
		checkWord("raData", raData, model[regIdxT'(`RA_REG)]);
		#1;
	endtask

	// Strobe low with a random word on the bus
	task automatic idleCycle();
		wordT w;
		w = randBits(32);
		instruction = w;
		instrValid = 1'b0;
		@(posedge clk);
		#1;
		checkFlag("resultValid", resultValid, 1'b0);
		checkFlag("illegal", illegal, 1'b0);
		checkWord("result", result, lastResult);
		checkWord("raData", raData, model[regIdxT'(`RA_REG)]);
		#1;
	endtask

	////////////////////
	// Stimulus
	initial
	begin
		wordT w;
		wordT t;
		regIdxT rd;
		regIdxT prevDest;
		logic [2:0] sel;
		clk = 1'b0;
		rst = 1'b1;
		// Legal JAL during reset must leave no trace
		instruction = encodeJ(26'h0000040);
		instrValid = 1'b1;
		pc = 32'h0000_0ffc;
		lfsrState = 16'd31645;
		lastResult = '0;
		pcNext = 32'h0000_1000;
		model = '{default: '0};
		repeat (2) @(posedge clk);
		#2;
		instrValid = 1'b0;
		@(posedge clk);
		#2;
		rst = 1'b0;
		idleCycle();

		// Every register reads zero after reset
		for (int k = 0; k < N_START; k++)
		begin
			issue(encodeR(FN_ADD, regIdxT'(k), regIdxT'(k), '0, '0), pcNext);
		end

		// Immediate forms that also fill the registers
		for (int k = 0; k < N_IMM; k++)
		begin
			w = randBits(16);
			t = randBits(3);
			sel = t[2:0];
			issue(encodeI(immOps[sel], randReg(), randReg(), w[15:0]), pcNext);
		end

		// R-type on random registers
		for (int k = 0; k < N_RTYPE; k++)
		begin
			w = randBits(5);
			t = randBits(3);
			sel = t[2:0];
			rd = randReg();
			// Extra writes to register 0
			if (randBits(3) == 0)
			begin
				rd = '0;
			end
			issue(encodeR(fnList[sel], randReg(), randReg(), rd, w[4:0]), pcNext);
		end

		// Dependent chain with random gaps
		prevDest = randReg();
		for (int k = 0; k < N_CHAIN; k++)
		begin
			rd = randReg();
			if (rd == '0)
			begin
				rd = regIdxT'(1);
			end
			if (k % 2 == 0)
			begin
				issue(encodeR(FN_ADD, prevDest, randReg(), rd, '0), pcNext);
			end
			else
			begin
				w = randBits(16);
				issue(encodeI(OP_ADDI, prevDest, rd, w[15:0]), pcNext);
			end
			prevDest = rd;
			w = randBits(1);
			if (w[0])
			begin
				idleCycle();
			end
		end

		// Jump-and-link followed by a read of register 31
		for (int k = 0; k < N_JAL; k++)
		begin
			w = randBits(30);
			t = randBits(26);
			issue(encodeJ(t[25:0]), {w[29:0], 2'b00});
			rd = randReg();
			if (rd == '0)
			begin
				rd = regIdxT'(1);
			end
			issue(encodeR(FN_OR, regIdxT'(`RA_REG), '0, rd, '0), pcNext);
		end

		// Unknown encodings with every second one R-type
		for (int k = 0; k < N_ILLEGAL; k++)
		begin
			do
			begin
				if (k % 2 == 0)
				begin
					// Opcode bits stay zero for R-type
					w = randBits(26);
				end
				else
				begin
					w = randBits(32);
				end
			end
			while (isLegal(w));
			issue(w, pcNext);
			// Both candidate destinations must be untouched
			issue(encodeR(FN_OR, w[20:16], w[15:11], '0, '0), pcNext);
		end

		idleCycle();
		idleCycle();
		$display("Result: PASSED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#((N_CYCLES + 50) * 20);
		$display("Watchdog expired before the tests completed");
		$display("Result: FAILED");
		$fatal(1, "Timeout");
	end

endmodule

// ==== tb.f ====
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/execIfs.sv
design/instrDecoder.sv
design/regFile.sv
design/aluUnit.sv
design/execCore.sv
tests/execCore_assert.sv
tests/execCoreTb.sv

// ==== Makefile ====
# Verilator simulation of the execute slice

VERILATOR ?= verilator
TOP ?= execCoreTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "Result: PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
